/* src/calc_pkg.sv */
package calc_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 4;

  // Codes outside this list decode as no-ops
  typedef enum logic [3:0]
  {
    ADD    = 4'h0
    , SUB  = 4'h1
    , AND  = 4'h2
    , OR   = 4'h3
    , XOR  = 4'h4
    , ADDI = 4'h5
    , MUL  = 4'h6
    , DIVU = 4'h7
    , REMU = 4'h8
  } calc_op_e;

  // Register form and immediate form share opcode, rd and rs1
  typedef union packed
  {
    struct packed
    {
      calc_op_e              opcode;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [15:0]           pad;
    } r;
    struct packed
    {
      calc_op_e              opcode;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] rs1;
      logic [3:0]            pad;
      logic [15:0]           imm;
    } i;
  } calc_instr_u;

endpackage

/* src/calc_regfile.sv */
`timescale 1ns/1ps

module calc_regfile
  import calc_pkg::*;
  #(parameter int NUM_REGS = 16)
  (input                          clk_i
   , input                        arst_n_i

   , input  [REG_ADDR_W-1:0]      rs1_addr_i
   , input  [REG_ADDR_W-1:0]      rs2_addr_i
   , output logic [XLEN-1:0]      rs1_data_o
   , output logic [XLEN-1:0]      rs2_data_o

   , input                        wr_en_i
   , input  [REG_ADDR_W-1:0]      wr_addr_i
   , input  [XLEN-1:0]            wr_data_i
   );

  logic [XLEN-1:0] regs_r [NUM_REGS];

  assign rs1_data_o = regs_r[rs1_addr_i];
  assign rs2_data_o = regs_r[rs2_addr_i];

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          for (int i = 0; i < NUM_REGS; i++)
            begin
              regs_r[i] <= '0;
            end
        end
      else if (wr_en_i)
        begin
          regs_r[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

/* src/calc_issue.sv */
`timescale 1ns/1ps

module calc_issue
  import calc_pkg::*;
  (input                            clk_i
   , input                          arst_n_i

   , input                          dispatch_v_i
   , input  calc_instr_u            dispatch_instr_i
   , input                          div_idle_i
   , output logic                   dispatch_ready_o

   , output logic [REG_ADDR_W-1:0]  rs1_addr_o
   , output logic [REG_ADDR_W-1:0]  rs2_addr_o
   , input  [XLEN-1:0]              rf_rs1_i
   , input  [XLEN-1:0]              rf_rs2_i

   , input  [XLEN-1:0]              s0_result_i
   , input                          s1_v_i
   , input  [REG_ADDR_W-1:0]        s1_rd_i
   , input  [XLEN-1:0]              s1_data_i
   , input                          s2_v_i
   , input  [REG_ADDR_W-1:0]        s2_rd_i
   , input  [XLEN-1:0]              s2_data_i

   , output logic                   s0_v_o
   , output calc_op_e               s0_op_o
   , output logic [REG_ADDR_W-1:0]  s0_rd_o
   , output logic [XLEN-1:0]        s0_a_o
   , output logic [XLEN-1:0]        s0_b_o
   );

  calc_op_e              op;
  logic [REG_ADDR_W-1:0] rs1, rs2;
  logic                  reads_rs1, reads_rs2, is_imm;
  logic                  s0_alu_wr, s0_mul, hazard, accept;
  logic [XLEN-1:0]       rs1_val, rs2_val, imm_ext;

  logic                  s0_v_r;
  calc_op_e              s0_op_r;
  logic [REG_ADDR_W-1:0] s0_rd_r;
  logic [XLEN-1:0]       s0_a_r, s0_b_r;

  assign op        = dispatch_instr_i.r.opcode;
  assign rs1       = dispatch_instr_i.r.rs1;
  assign rs2       = dispatch_instr_i.r.rs2;
  assign imm_ext   = {{(XLEN-16){dispatch_instr_i.i.imm[15]}}, dispatch_instr_i.i.imm};
  assign is_imm    = (op == ADDI);
  assign reads_rs1 = (op inside {ADD, SUB, AND, OR, XOR, ADDI, MUL, DIVU, REMU});
  assign reads_rs2 = reads_rs1 & ~is_imm;

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  // Only single-cycle results are ready in stage 0
  assign s0_alu_wr = s0_v_r & (s0_op_r inside {ADD, SUB, AND, OR, XOR, ADDI});
  assign s0_mul    = s0_v_r & (s0_op_r == MUL);

  // Youngest match wins
  assign rs1_val = (s0_alu_wr && s0_rd_r == rs1) ? s0_result_i
                 : (s1_v_i && s1_rd_i == rs1)    ? s1_data_i
                 : (s2_v_i && s2_rd_i == rs1)    ? s2_data_i
                 : rf_rs1_i;
  assign rs2_val = (s0_alu_wr && s0_rd_r == rs2) ? s0_result_i
                 : (s1_v_i && s1_rd_i == rs2)    ? s1_data_i
                 : (s2_v_i && s2_rd_i == rs2)    ? s2_data_i
                 : rf_rs2_i;

  assign hazard = s0_mul & ((reads_rs1 & (rs1 == s0_rd_r)) | (reads_rs2 & (rs2 == s0_rd_r)));
  assign dispatch_ready_o = div_idle_i & ~hazard;
  assign accept = dispatch_v_i & dispatch_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        s0_v_r <= 1'b0;
      else
        s0_v_r <= accept;
    end

  always_ff @(posedge clk_i)
    begin
      s0_op_r <= op;
      s0_rd_r <= dispatch_instr_i.r.rd;
      s0_a_r  <= rs1_val;
      s0_b_r  <= is_imm ? imm_ext : rs2_val;
    end

  assign s0_v_o  = s0_v_r;
  assign s0_op_o = s0_op_r;
  assign s0_rd_o = s0_rd_r;
  assign s0_a_o  = s0_a_r;
  assign s0_b_o  = s0_b_r;

endmodule

/* src/calc_pipe_arith.sv */
`timescale 1ns/1ps

module calc_pipe_arith
  import calc_pkg::*;
  (input                        clk_i
   , input                      arst_n_i

   , input  calc_op_e           s0_op_i
   , input  [XLEN-1:0]          s0_a_i
   , input  [XLEN-1:0]          s0_b_i

   , output logic [XLEN-1:0]    alu_result_o
   , output logic [XLEN-1:0]    mul_result_o
   );

  logic [XLEN-1:0] mul_r;

  always_comb
    begin
      case (s0_op_i)
        ADD, ADDI: alu_result_o = s0_a_i + s0_b_i;
        SUB:       alu_result_o = s0_a_i - s0_b_i;
        AND:       alu_result_o = s0_a_i & s0_b_i;
        OR:        alu_result_o = s0_a_i | s0_b_i;
        XOR:       alu_result_o = s0_a_i ^ s0_b_i;
        default:   alu_result_o = '0;
      endcase
    end

  // Low half of the product, ready one cycle after stage 0
  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          mul_r <= '0;
        end
      else if (s0_op_i == MUL)
        begin
          mul_r <= s0_a_i * s0_b_i;
        end
    end

  assign mul_result_o = mul_r;

endmodule

/* src/calc_div_count.sv */
`timescale 1ns/1ps

module calc_div_count
  #(parameter int DIV_STEPS = 32)
  (input          clk_i
   , input        arst_n_i

   , input        load_i
   , input        step_i
   , output logic done_o
   );

  localparam int CNT_W = (DIV_STEPS > 1) ? $clog2(DIV_STEPS) : 1;
  localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(DIV_STEPS - 1);

  logic [CNT_W-1:0] count_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        count_r <= '0;
      else if (load_i)
        count_r <= LOAD_VAL;
      else if (step_i && count_r != '0)
        count_r <= count_r - 1'b1;
    end

  // High during the last step
  assign done_o = (count_r == '0);

endmodule

/* src/calc_div_datapath.sv */
`timescale 1ns/1ps

module calc_div_datapath
  import calc_pkg::*;
  (input                            clk_i
   , input                          arst_n_i

   , input                          load_i
   , input                          step_i
   , input  [XLEN-1:0]              dividend_i
   , input  [XLEN-1:0]              divisor_i
   , input  [REG_ADDR_W-1:0]        rd_i
   , input                          want_rem_i

   , output logic [XLEN-1:0]        result_o
   , output logic [REG_ADDR_W-1:0]  rd_o
   );

  logic [XLEN-1:0]       rem_r, quo_r, dvsr_r;
  logic [REG_ADDR_W-1:0] rd_r;
  logic                  want_rem_r;
  logic [XLEN:0]         rem_shift, diff;
  logic                  q_bit;

  // Top bit of diff is the borrow
  assign rem_shift = {rem_r, quo_r[XLEN-1]};
  assign diff      = rem_shift - {1'b0, dvsr_r};
  assign q_bit     = ~diff[XLEN];

  // A zero divisor never borrows, so the quotient fills with ones
  always_ff @(posedge clk_i)
    begin
      if (load_i)
        begin
          rem_r  <= '0;
          quo_r  <= dividend_i;
          dvsr_r <= divisor_i;
        end
      else if (step_i)
        begin
          rem_r <= q_bit ? diff[XLEN-1:0] : rem_shift[XLEN-1:0];
          quo_r <= {quo_r[XLEN-2:0], q_bit};
        end
    end

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          rd_r       <= '0;
          want_rem_r <= 1'b0;
        end
      else if (load_i)
        begin
          rd_r       <= rd_i;
          want_rem_r <= want_rem_i;
        end
    end

  assign result_o = want_rem_r ? rem_r : quo_r;
  assign rd_o     = rd_r;

endmodule

/* src/calc_div_ctrl.sv */
`timescale 1ns/1ps

module calc_div_ctrl
  (input          clk_i
   , input        arst_n_i

   , input        start_i
   , input        count_done_i
   , input        wb_yumi_i

   , output logic load_o
   , output logic step_o
   , output logic idle_o
   , output logic wb_v_o
   );

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_RUN  = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0] state_r, state_n;

  always_comb
    begin
      state_n = state_r;
      case (state_r)
        ST_IDLE: if (start_i)      state_n = ST_RUN;
        ST_RUN:  if (count_done_i) state_n = ST_DONE;
        ST_DONE: if (wb_yumi_i)    state_n = ST_IDLE;
        default:                   state_n = ST_IDLE;
      endcase
    end

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        state_r <= ST_IDLE;
      else
        state_r <= state_n;
    end

  assign load_o = (state_r == ST_IDLE) & start_i;
  assign step_o = (state_r == ST_RUN);
  // Busy already while the divide waits in stage 0
  assign idle_o = (state_r == ST_IDLE) & ~start_i;
  assign wb_v_o = (state_r == ST_DONE);

endmodule

/* src/calc_comp_pipe.sv */
`timescale 1ns/1ps

module calc_comp_pipe
  import calc_pkg::*;
  (input                            clk_i
   , input                          arst_n_i

   , input                          s0_v_i
   , input  calc_op_e               s0_op_i
   , input  [REG_ADDR_W-1:0]        s0_rd_i
   , input  [XLEN-1:0]              alu_result_i
   , input  [XLEN-1:0]              mul_result_i

   , output logic                   s1_v_o
   , output logic [REG_ADDR_W-1:0]  s1_rd_o
   , output logic [XLEN-1:0]        s1_data_o
   , output logic                   s2_v_o
   , output logic [REG_ADDR_W-1:0]  s2_rd_o
   , output logic [XLEN-1:0]        s2_data_o
   );

  logic                  s1_v_r, s1_mul_r, s2_v_r;
  logic [REG_ADDR_W-1:0] s1_rd_r, s2_rd_r;
  logic [XLEN-1:0]       s1_data_r, s2_data_r;
  logic                  s1_v_n;

  // Divides leave through the late writeback, no-ops write nothing
  assign s1_v_n = s0_v_i & (s0_op_i inside {ADD, SUB, AND, OR, XOR, ADDI, MUL});

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          s1_v_r   <= 1'b0;
          s1_mul_r <= 1'b0;
          s2_v_r   <= 1'b0;
        end
      else
        begin
          s1_v_r   <= s1_v_n;
          s1_mul_r <= s1_v_n & (s0_op_i == MUL);
          s2_v_r   <= s1_v_r;
        end
    end

  always_ff @(posedge clk_i)
    begin
      s1_rd_r   <= s0_rd_i;
      s1_data_r <= alu_result_i;
      s2_rd_r   <= s1_rd_r;
      s2_data_r <= s1_data_o;
    end

  // Product merges here so stage 1 forwards a ready value
  assign s1_data_o = s1_mul_r ? mul_result_i : s1_data_r;

  assign s1_v_o    = s1_v_r;
  assign s1_rd_o   = s1_rd_r;
  assign s2_v_o    = s2_v_r;
  assign s2_rd_o   = s2_rd_r;
  assign s2_data_o = s2_data_r;

endmodule

/* src/calc_top.sv */
`timescale 1ns/1ps

module calc_top
  import calc_pkg::*;
  #(parameter int DIV_STEPS = 32
    , parameter int NUM_REGS = 16
    )
  (input                            clk_i
   , input                          arst_n_i

   , input                          dispatch_v_i
   , input  calc_instr_u            dispatch_instr_i
   , output logic                   dispatch_ready_o

   , output logic                   iwb_v_o
   , output logic [REG_ADDR_W-1:0]  iwb_addr_o
   , output logic [XLEN-1:0]        iwb_data_o

   , output logic                   div_wb_v_o
   , output logic [REG_ADDR_W-1:0]  div_wb_addr_o
   , output logic [XLEN-1:0]        div_wb_data_o
   , input                          div_wb_yumi_i
   );

  logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, s0_rd, s1_rd, s2_rd, rf_wr_addr;
  logic [XLEN-1:0]       rf_rs1, rf_rs2, rf_wr_data;
  logic [XLEN-1:0]       s0_a, s0_b, alu_result, mul_result, s1_data, s2_data;
  logic                  s0_v, s1_v, s2_v, rf_wr_en;
  calc_op_e              s0_op;
  logic                  div_start, div_load, div_step, div_idle, div_count_done;

  calc_issue issue
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.dispatch_v_i(dispatch_v_i)
     ,.dispatch_instr_i(dispatch_instr_i)
     ,.div_idle_i(div_idle)
     ,.dispatch_ready_o(dispatch_ready_o)
     ,.rs1_addr_o(rs1_addr)
     ,.rs2_addr_o(rs2_addr)
     ,.rf_rs1_i(rf_rs1)
     ,.rf_rs2_i(rf_rs2)
     ,.s0_result_i(alu_result)
     ,.s1_v_i(s1_v)
     ,.s1_rd_i(s1_rd)
     ,.s1_data_i(s1_data)
     ,.s2_v_i(s2_v)
     ,.s2_rd_i(s2_rd)
     ,.s2_data_i(s2_data)
     ,.s0_v_o(s0_v)
     ,.s0_op_o(s0_op)
     ,.s0_rd_o(s0_rd)
     ,.s0_a_o(s0_a)
     ,.s0_b_o(s0_b)
     );

  calc_pipe_arith pipe_arith
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.s0_op_i(s0_op)
     ,.s0_a_i(s0_a)
     ,.s0_b_i(s0_b)
     ,.alu_result_o(alu_result)
     ,.mul_result_o(mul_result)
     );

  calc_comp_pipe comp_pipe
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.s0_v_i(s0_v)
     ,.s0_op_i(s0_op)
     ,.s0_rd_i(s0_rd)
     ,.alu_result_i(alu_result)
     ,.mul_result_i(mul_result)
     ,.s1_v_o(s1_v)
     ,.s1_rd_o(s1_rd)
     ,.s1_data_o(s1_data)
     ,.s2_v_o(s2_v)
     ,.s2_rd_o(s2_rd)
     ,.s2_data_o(s2_data)
     );

  // Long pipe for unsigned divide and remainder
  assign div_start = s0_v & (s0_op inside {DIVU, REMU});

  calc_div_ctrl div_ctrl
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.start_i(div_start)
     ,.count_done_i(div_count_done)
     ,.wb_yumi_i(div_wb_yumi_i)
     ,.load_o(div_load)
     ,.step_o(div_step)
     ,.idle_o(div_idle)
     ,.wb_v_o(div_wb_v_o)
     );

  calc_div_count #(.DIV_STEPS(DIV_STEPS)) div_count
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.load_i(div_load)
     ,.step_i(div_step)
     ,.done_o(div_count_done)
     );

  calc_div_datapath div_datapath
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.load_i(div_load)
     ,.step_i(div_step)
     ,.dividend_i(s0_a)
     ,.divisor_i(s0_b)
     ,.rd_i(s0_rd)
     ,.want_rem_i(s0_op == REMU)
     ,.result_o(div_wb_data_o)
     ,.rd_o(div_wb_addr_o)
     );

  // Late writeback takes the write port in its yumi cycle
  assign rf_wr_en   = div_wb_yumi_i | s2_v;
  assign rf_wr_addr = div_wb_yumi_i ? div_wb_addr_o : s2_rd;
  assign rf_wr_data = div_wb_yumi_i ? div_wb_data_o : s2_data;

  calc_regfile #(.NUM_REGS(NUM_REGS)) regfile
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.rs1_addr_i(rs1_addr)
     ,.rs2_addr_i(rs2_addr)
     ,.rs1_data_o(rf_rs1)
     ,.rs2_data_o(rf_rs2)
     ,.wr_en_i(rf_wr_en)
     ,.wr_addr_i(rf_wr_addr)
     ,.wr_data_i(rf_wr_data)
     );

  assign iwb_v_o    = s2_v;
  assign iwb_addr_o = s2_rd;
  assign iwb_data_o = s2_data;

endmodule

/* sim/calc_sva.sv */
`timescale 1ns/1ps

module calc_sva
  import calc_pkg::*;
  (input                          clk_i
   , input                        arst_n_i
   , input                        dispatch_ready_o
   , input                        iwb_v_o
   , input                        div_wb_v_o
   , input  [REG_ADDR_W-1:0]      div_wb_addr_o
   , input  [XLEN-1:0]            div_wb_data_o
   , input                        div_wb_yumi_i
   );

  // Late writeback holds until taken
  div_wb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    div_wb_v_o && !div_wb_yumi_i |=>
      div_wb_v_o && $stable(div_wb_addr_o) && $stable(div_wb_data_o))
    else $error("late writeback changed before yumi");

  yumi_with_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    div_wb_yumi_i |-> div_wb_v_o)
    else $error("yumi without late writeback valid");

  // One write port on the register file
  one_writer: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(iwb_v_o && div_wb_yumi_i))
    else $error("integer writeback and yumi in the same cycle");

  busy_while_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    div_wb_v_o |-> !dispatch_ready_o)
    else $error("dispatch ready while divide result waits");

endmodule

bind calc_top calc_sva sva (.*);

/* sim/calc_tb.sv */
`timescale 1ns/1ps

module calc_tb
  import calc_pkg::*;
  ();

  // About 40 cycles per instruction covers the longest divide with its yumi delay
  localparam int PLANNED     = 172;
  localparam int CYCLE_LIMIT = 40 * PLANNED + 100;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  dispatch_v_i;
  calc_instr_u           dispatch_instr_i;
  logic                  dispatch_ready_o;
  logic                  iwb_v_o;
  logic [REG_ADDR_W-1:0] iwb_addr_o;
  logic [XLEN-1:0]       iwb_data_o;
  logic                  div_wb_v_o;
  logic [REG_ADDR_W-1:0] div_wb_addr_o;
  logic [XLEN-1:0]       div_wb_data_o;
  logic                  div_wb_yumi_i;

  integer                seed;
  int                    cycle_cnt, err_cnt, check_cnt, test_err, test_instr;
  logic                  acc_seen;
  logic [XLEN-1:0]       model_rf [16];
  logic [REG_ADDR_W-1:0] exp_rd_q [$];
  logic [XLEN-1:0]       exp_data_q [$];
  int                    exp_cyc_q [$];
  logic                  div_busy, div_seen_v, ready_after_yumi;
  logic [REG_ADDR_W-1:0] div_rd;
  logic [XLEN-1:0]       div_data;
  logic                  prev_mul;
  logic [REG_ADDR_W-1:0] prev_rd;
  int                    prev_cyc;

  calc_top #(.DIV_STEPS(32), .NUM_REGS(16)) dut (.*);

  always #5 clk_i = ~clk_i;

  function automatic calc_instr_u make_r(calc_op_e op, logic [3:0] rd, logic [3:0] rs1,
                                         logic [3:0] rs2);
    calc_instr_u w;
    w          = '0;
    w.r.opcode = op;
    w.r.rd     = rd;
    w.r.rs1    = rs1;
    w.r.rs2    = rs2;
    return w;
  endfunction

  function automatic calc_instr_u make_i(calc_op_e op, logic [3:0] rd, logic [3:0] rs1,
                                         logic [15:0] imm);
    calc_instr_u w;
    w          = '0;
    w.i.opcode = op;
    w.i.rd     = rd;
    w.i.rs1    = rs1;
    w.i.imm    = imm;
    return w;
  endfunction

  // Unsigned divide by zero gives all ones, remainder keeps the dividend
  function automatic logic [XLEN-1:0] expect_result(calc_op_e op, logic [XLEN-1:0] a,
                                                    logic [XLEN-1:0] b);
    case (op)
      ADD, ADDI: return a + b;
      SUB:       return a - b;
      AND:       return a & b;
      OR:        return a | b;
      XOR:       return a ^ b;
      MUL:       return a * b;
      DIVU:      return (b == '0) ? '1 : a / b;
      REMU:      return (b == '0) ? a : a % b;
      default:   return '0;
    endcase
  endfunction

  // Only four registers, so results are reused often
  function automatic logic [3:0] pick_reg();
    return 4'($unsigned($random(seed)) % 4);
  endfunction

  function automatic logic [15:0] rand_imm();
    return 16'($random(seed));
  endfunction

  function automatic calc_op_e pick_op();
    case ($unsigned($random(seed)) % 6)
      0:       return ADD;
      1:       return SUB;
      2:       return AND;
      3:       return OR;
      4:       return XOR;
      default: return ADDI;
    endcase
  endfunction

  task automatic check_wb(input string name, input logic [REG_ADDR_W-1:0] got_addr,
                          input logic [XLEN-1:0] got_data,
                          input logic [REG_ADDR_W-1:0] exp_addr,
                          input logic [XLEN-1:0] exp_data);
    check_cnt++;
    if (got_addr !== exp_addr)
    begin
      err_cnt++;
      $display("Mismatch at %0t: %s_addr got %0d expected %0d", $time, name, got_addr,
               exp_addr);
    end
    if (got_data !== exp_data)
    begin
      err_cnt++;
      $display("Mismatch at %0t: %s_data got %h expected %h", $time, name, got_data,
               exp_data);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Drivers enter and leave 1 ns after a rising edge
  task automatic send(input calc_instr_u w);
    dispatch_v_i     = 1'b1;
    dispatch_instr_i = w;
    @(posedge clk_i);
    while (!acc_seen)
      @(posedge clk_i);
    #1;
    dispatch_v_i = 1'b0;
  endtask

  task automatic run_div(input calc_instr_u w, input int max_delay);
    int delay;
    send(w);
    while (!div_wb_v_o)
    begin
      @(posedge clk_i);
      #1;
    end
    delay = $unsigned($random(seed)) % (max_delay + 1);
    repeat (delay)
    begin
      @(posedge clk_i);
      #1;
    end
    div_wb_yumi_i = 1'b1;
    @(posedge clk_i);
    #1;
    div_wb_yumi_i = 1'b0;
  endtask

  task automatic start_test();
    test_err   = err_cnt;
    test_instr = 0;
  endtask

  task automatic end_test(input string name);
    while (exp_rd_q.size() != 0 || div_busy)
    begin
      @(posedge clk_i);
      #1;
    end
    repeat (2)
    begin
      @(posedge clk_i);
      #1;
    end
    $display("Test %s: %0d instructions, %0d errors", name, test_instr, err_cnt - test_err);
  endtask

  // Sample at the falling edge, where inputs and outputs are settled
  always @(negedge clk_i)
  begin : monitor
    calc_op_e              op;
    logic [REG_ADDR_W-1:0] rd, rs1, rs2, q_rd;
    logic [XLEN-1:0]       a, b, res, q_data;
    int                    q_cyc;
    acc_seen = dispatch_v_i & dispatch_ready_o;
    if (arst_n_i)
    begin
      if (iwb_v_o && exp_rd_q.size() == 0)
      begin
        err_cnt++;
        $display("Unexpected integer writeback at %0t to register %0d", $time, iwb_addr_o);
      end
      else if (iwb_v_o)
      begin
        q_rd   = exp_rd_q.pop_front();
        q_data = exp_data_q.pop_front();
        q_cyc  = exp_cyc_q.pop_front();
        check_wb("iwb", iwb_addr_o, iwb_data_o, q_rd, q_data);
        if (cycle_cnt != q_cyc + 3)
        begin
          err_cnt++;
          $display("Integer writeback at %0t came in cycle %0d instead of cycle %0d",
                   $time, cycle_cnt, q_cyc + 3);
        end
      end
      if (div_wb_v_o && !div_busy)
      begin
        err_cnt++;
        $display("Late writeback valid at %0t with no divide in flight", $time);
      end
      else if (div_wb_v_o)
      begin
        check_wb("div_wb", div_wb_addr_o, div_wb_data_o, div_rd, div_data);
        div_seen_v = 1'b1;
      end
      else if (div_seen_v)
      begin
        err_cnt++;
        $display("Late writeback valid dropped at %0t before it was taken", $time);
        div_seen_v = 1'b0;
      end
      if (ready_after_yumi)
      begin
        check_flag("dispatch_ready_o", dispatch_ready_o, 1'b1);
        ready_after_yumi = 1'b0;
      end
      if (div_busy)
      begin
        check_flag("dispatch_ready_o", dispatch_ready_o, 1'b0);
        if (div_wb_yumi_i)
        begin
          div_busy         = 1'b0;
          div_seen_v       = 1'b0;
          ready_after_yumi = 1'b1;
        end
      end
      if (acc_seen)
      begin
        op  = dispatch_instr_i.r.opcode;
        rd  = dispatch_instr_i.r.rd;
        rs1 = dispatch_instr_i.r.rs1;
        rs2 = dispatch_instr_i.r.rs2;
        a   = model_rf[rs1];
        b   = (op == ADDI) ? {{(XLEN-16){dispatch_instr_i.i.imm[15]}}, dispatch_instr_i.i.imm}
                           : model_rf[rs2];
        res = expect_result(op, a, b);
        if (prev_mul && cycle_cnt - prev_cyc < 2 &&
            (rs1 == prev_rd || (op != ADDI && rs2 == prev_rd)))
        begin
          err_cnt++;
          $display("Instruction reading a MUL result was accepted one cycle after the MUL");
        end
        prev_mul = (op == MUL);
        prev_rd  = rd;
        prev_cyc = cycle_cnt;
        test_instr++;
        if (op == DIVU || op == REMU)
        begin
          div_busy = 1'b1;
          div_rd   = rd;
          div_data = res;
        end
        else
        begin
          exp_rd_q.push_back(rd);
          exp_data_q.push_back(res);
          exp_cyc_q.push_back(cycle_cnt);
        end
        model_rf[rd] = res;
      end
    end
  end

  initial
  begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    int                    n;
    logic [REG_ADDR_W-1:0] d;
    calc_op_e              op;
    seed             = 32'h4fad_6249;
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    dispatch_v_i     = 1'b0;
    dispatch_instr_i = '0;
    div_wb_yumi_i    = 1'b0;
    err_cnt          = 0;
    check_cnt        = 0;
    acc_seen         = 1'b0;
    div_busy         = 1'b0;
    div_seen_v       = 1'b0;
    ready_after_yumi = 1'b0;
    prev_mul         = 1'b0;
    prev_rd          = '0;
    prev_cyc         = 0;
    for (int i = 0; i < 16; i++)
      model_rf[i] = '0;
    repeat (8) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    start_test();
    repeat (6)
    begin
      @(negedge clk_i);
      check_flag("dispatch_ready_o", dispatch_ready_o, 1'b1);
      check_flag("iwb_v_o", iwb_v_o, 1'b0);
      check_flag("div_wb_v_o", div_wb_v_o, 1'b0);
    end
    @(posedge clk_i);
    #1;
    end_test("1 reset_state");

    start_test();
    for (n = 0; n < 64; n++)
    begin
      op = pick_op();
      if (op == ADDI)
        send(make_i(ADDI, pick_reg(), pick_reg(), rand_imm()));
      else
        send(make_r(op, pick_reg(), pick_reg(), pick_reg()));
    end
    end_test("2 alu_stream");

    start_test();
    for (n = 0; n < 12; n++)
    begin
      d  = pick_reg();
      op = pick_op();
      send(make_r(MUL, d, pick_reg(), pick_reg()));
      if (op == ADDI)
        send(make_i(ADDI, pick_reg(), d, rand_imm()));
      else
        send(make_r(op, pick_reg(), pick_reg(), d));
      send(make_i(ADDI, pick_reg(), d, rand_imm()));
    end
    end_test("3 mul_dependency");

    // Wide dividend from a square, divisor forced to zero for both DIVU and REMU
    start_test();
    for (n = 0; n < 16; n++)
    begin
      if (n == 8)
      begin
        end_test("4 divide");
        start_test();
      end
      d = pick_reg();
      send(make_i(ADDI, 4'd4, 4'd4, rand_imm()));
      send(make_r(MUL, 4'd6, 4'd4, 4'd4));
      if (n % 3 == 1)
        send(make_r(SUB, 4'd8, 4'd8, 4'd8));
      else
        send(make_i(ADDI, 4'd8, 4'd3, rand_imm()));
      run_div(make_r((n % 2 == 1) ? REMU : DIVU, d, 4'd6, 4'd8), (n < 8) ? 0 : 10);
      if (n >= 8)
        send(make_r(ADD, pick_reg(), d, 4'd6));
    end
    end_test("5 divide_yumi_delay");

    $display("Summary: %0d checks, %0d errors, %0d cycles", check_cnt, err_cnt, cycle_cnt);
    if (err_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* src.f */
src/calc_pkg.sv
src/calc_regfile.sv
src/calc_issue.sv
src/calc_pipe_arith.sv
src/calc_div_count.sv
src/calc_div_datapath.sv
src/calc_div_ctrl.sv
src/calc_comp_pipe.sv
src/calc_top.sv
sim/calc_sva.sv
sim/calc_tb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -j 0 --top-module calc_tb -f src.f -o calc_sim \
  && ./obj_dir/calc_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
  && echo "Simulation run OK" \
  || { echo "Simulation run not OK"; exit 1; }
